// File: source/game_pkg.sv
`default_nettype none

package game_pkg;

	// Bar and timing constants.
	localparam logic [4:0] bar_full = 5'd16; // All sixteen LEDs lit.
	localparam int tick_cycles = 8; // Short tick so a game fits in simulation.
	localparam int tick_cnt_w = $clog2(tick_cycles);
	localparam logic [tick_cnt_w-1:0] tick_last = tick_cnt_w'(tick_cycles - 1);

	localparam int scan_cycles = 4; // Cycles per digit.
	localparam int scan_cnt_w = $clog2(scan_cycles);
	localparam logic [scan_cnt_w-1:0] scan_last = scan_cnt_w'(scan_cycles - 1);

	// Score saturates at 99.
	localparam logic [3:0] score_max_tens = 4'd9;
	localparam logic [3:0] score_max_units = 4'd9;

	typedef enum logic [1:0]
	{
		st_idle     = 2'd0,
		st_classic  = 2'd1,
		st_infinity = 2'd2,
		st_over     = 2'd3
	} game_state_t;

	// Digit shown in the leftmost position.
	localparam logic [3:0] mode_code_none = 4'd0;
	localparam logic [3:0] mode_code_classic = 4'd1;
	localparam logic [3:0] mode_code_infinity = 4'd2;

	// Active low, segment a in bit 6 down to segment g in bit 0.
	localparam logic [6:0] seg_table [0:9] =
	'{
		7'b000_0001, // 0
		7'b100_1111, // 1
		7'b001_0010, // 2
		7'b000_0110, // 3
		7'b100_1100, // 4
		7'b010_0100, // 5
		7'b010_0000, // 6
		7'b000_1111, // 7
		7'b000_0000, // 8
		7'b000_0100  // 9
	};

	localparam logic [6:0] seg_blank = 7'b111_1111; // Everything dark.

endpackage

`default_nettype wire

// File: source/seg7_scan.sv
`timescale 1ns/1ps
`default_nettype none

module seg7_scan
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic [15:0] data,
	input  logic        blank,
	output logic [3:0]  an,
	output logic [6:0]  seg
);

	logic [game_pkg::scan_cnt_w-1:0] scan_cnt;
	logic [1:0]                      digit; // Digit being driven now.
	logic [3:0]                      nibble;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			scan_cnt <= '0;
			digit <= 2'd0;
		end
		else if (scan_cnt == game_pkg::scan_last)
		begin
			scan_cnt <= '0;
			digit <= digit + 2'd1; // Wraps from 3 back to 0.
		end
		else
		begin
			scan_cnt <= scan_cnt + 1'b1;
		end
	end

	assign an = ~(4'b0001 << digit); // One anode low at a time.
	assign nibble = data[digit*4 +: 4];

	always_comb
	begin
		if (blank)
			seg = game_pkg::seg_blank;
		else if (nibble > 4'd9)
			seg = game_pkg::seg_blank; // No glyph above nine.
		else
			seg = game_pkg::seg_table[nibble];
	end

endmodule

`default_nettype wire

// File: source/game_seg_and_led.sv
`timescale 1ns/1ps
`default_nettype none

module game_seg_and_led
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        running,
	input  logic [1:0]  mode,
	input  logic [4:0]  level,
	input  logic [3:0]  tens,
	input  logic [3:0]  units,
	input  logic        blank,
	output logic [15:0] led,
	output logic [3:0]  an,
	output logic [6:0]  seg
);

	logic [15:0] led_fill;
	logic [15:0] disp_word;

	// Thermometer from bit 15 down, level 16 lights all of them.
	assign led_fill = ~(16'hffff >> level);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			led <= 16'h0000;
		else if (!running)
			led <= 16'h0000; // Dark between games.
		else
			led <= led_fill;
	end

	// Digits 3 to 0 hold mode, a fixed zero, tens and units.
	always_ff @(posedge clk)
	begin
		disp_word <= {2'b00, mode, 4'd0, tens, units};
	end

	seg7_scan seg7_scan_i
	(
		.clk   (clk),
		.rst_n (rst_n),
		.data  (disp_word),
		.blank (blank),
		.an    (an),
		.seg   (seg)
	);

endmodule

`default_nettype wire

// File: source/game_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module game_fsm
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       start_classic,
	input  logic       start_infinity,
	input  logic       hit,
	input  logic       expired,
	output logic       load,
	output logic       refill,
	output logic       running,
	output logic       clear,
	output logic       score_inc,
	output logic [1:0] mode
);

	game_pkg::game_state_t state_q;
	game_pkg::game_state_t state_d;
	logic [1:0] last_mode_q; // Mode of the current or last game.
	logic       can_start;
	logic       hit_ok;

	assign can_start = (state_q == game_pkg::st_idle) || (state_q == game_pkg::st_over);
	assign running = (state_q == game_pkg::st_classic) || (state_q == game_pkg::st_infinity);

	// An empty bar ends the game, so a late hit is not counted.
	assign hit_ok = running && hit && !expired;

	assign load = can_start && (start_classic || start_infinity);
	assign clear = load; // Score restarts with every new game.
	assign score_inc = hit_ok;
	assign refill = hit_ok && (state_q == game_pkg::st_infinity);

	// Over keeps showing the mode that just ended.
	assign mode = (state_q == game_pkg::st_idle) ? game_pkg::mode_code_none[1:0] : last_mode_q;

	always_comb
	begin
		state_d = state_q;
		case (state_q)
			game_pkg::st_idle,
			game_pkg::st_over:
			begin
				if (start_classic)
					state_d = game_pkg::st_classic; // Classic wins a tie.
				else if (start_infinity)
					state_d = game_pkg::st_infinity;
			end
			game_pkg::st_classic,
			game_pkg::st_infinity:
			begin
				if (expired)
					state_d = game_pkg::st_over;
			end
			default: state_d = game_pkg::st_idle;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state_q <= game_pkg::st_idle;
			last_mode_q <= game_pkg::mode_code_none[1:0];
		end
		else
		begin
			state_q <= state_d;
			if (load)
			begin
				if (start_classic)
					last_mode_q <= game_pkg::mode_code_classic[1:0];
				else
					last_mode_q <= game_pkg::mode_code_infinity[1:0];
			end
		end
	end

endmodule

`default_nettype wire

// File: source/game_timer.sv
`timescale 1ns/1ps
`default_nettype none

module game_timer
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       load,
	input  logic       refill,
	input  logic       running,
	output logic [4:0] level,
	output logic       expired
);

	logic [game_pkg::tick_cnt_w-1:0] tick_cnt; // Cycles since the last decrement.

	assign expired = (level == 5'd0);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			level <= 5'd0;
			tick_cnt <= '0;
		end
		else if (load || refill)
		begin
			// Refill beats a tick in the same cycle.
			level <= game_pkg::bar_full;
			tick_cnt <= '0;
		end
		else if (running && !expired)
		begin
			if (tick_cnt == game_pkg::tick_last)
			begin
				tick_cnt <= '0;
				level <= level - 5'd1; // One LED fewer.
			end
			else
			begin
				tick_cnt <= tick_cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: source/score_counter.sv
`timescale 1ns/1ps
`default_nettype none

module score_counter
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       clear,
	input  logic       score_inc,
	output logic [3:0] tens,
	output logic [3:0] units
);

	logic at_max;

	assign at_max = (tens == game_pkg::score_max_tens) && (units == game_pkg::score_max_units);

	always_ff @(posedge clk)
	begin
		if (!rst_n || clear)
		begin
			tens <= 4'd0;
			units <= 4'd0;
		end
		else if (score_inc && !at_max)
		begin
			if (units == 4'd9)
			begin
				units <= 4'd0; // Decimal carry.
				tens <= tens + 4'd1;
			end
			else
			begin
				units <= units + 4'd1;
			end
		end
	end

endmodule

`default_nettype wire

// File: source/game_top.sv
`timescale 1ns/1ps
`default_nettype none

module game_top
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        start_classic,
	input  logic        start_infinity,
	input  logic        hit,
	input  logic [15:0] sw,
	output logic [15:0] led,
	output logic [3:0]  an,
	output logic [6:0]  seg,
	output logic        active
);

	logic       load;
	logic       refill;
	logic       running;
	logic       clear;
	logic       score_inc;
	logic       expired;
	logic [1:0] mode;
	logic [4:0] level;
	logic [3:0] tens;
	logic [3:0] units;

	assign active = running;

	game_fsm game_fsm_i
	(
		.clk            (clk),
		.rst_n          (rst_n),
		.start_classic  (start_classic),
		.start_infinity (start_infinity),
		.hit            (hit),
		.expired        (expired),
		.load           (load),
		.refill         (refill),
		.running        (running),
		.clear          (clear),
		.score_inc      (score_inc),
		.mode           (mode)
	);

	game_timer game_timer_i
	(
		.clk     (clk),
		.rst_n   (rst_n),
		.load    (load),
		.refill  (refill),
		.running (running),
		.level   (level),
		.expired (expired)
	);

	score_counter score_counter_i
	(
		.clk       (clk),
		.rst_n     (rst_n),
		.clear     (clear),
		.score_inc (score_inc),
		.tens      (tens),
		.units     (units)
	);

	// Only sw[0] matters on this board and it blanks the digits.
	game_seg_and_led game_seg_and_led_i
	(
		.clk     (clk),
		.rst_n   (rst_n),
		.running (running),
		.mode    (mode),
		.level   (level),
		.tens    (tens),
		.units   (units),
		.blank   (sw[0]),
		.led     (led),
		.an      (an),
		.seg     (seg)
	);

endmodule

`default_nettype wire

// File: dv/game_properties.sv
`timescale 1ns/1ps
`default_nettype none

module game_properties
(
	input logic        clk,
	input logic        rst_n,
	input logic        running,
	input logic [3:0]  units,
	input logic [15:0] led,
	input logic [3:0]  an
);

	logic [15:0] dark; // LEDs that are off.
	logic [15:0] dark_inc;
	int          fail_cnt = 0; // Assertion failures so far.

	assign dark = ~led;
	assign dark_inc = dark + 16'd1;

	one_digit_a: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot(~an))
		else
		begin
			fail_cnt++;
			$error("digit select does not have exactly one low bit");
		end

	// Dark LEDs sit in one run from bit 0 up.
	led_run_a: assert property (@(posedge clk) disable iff (!rst_n)
		(dark & dark_inc) == 16'd0)
		else
		begin
			fail_cnt++;
			$error("LED bar is not one run from LED 15");
		end

	led_off_a: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(running) |=> (led == 16'd0))
		else
		begin
			fail_cnt++;
			$error("LED bar still lit after the game ended");
		end

	units_a: assert property (@(posedge clk) disable iff (!rst_n)
		units <= 4'd9)
		else
		begin
			fail_cnt++;
			$error("score units digit above nine");
		end

endmodule

bind game_seg_and_led game_properties game_properties_i
(
	.clk     (clk),
	.rst_n   (rst_n),
	.running (running),
	.units   (units),
	.led     (led),
	.an      (an)
);

`default_nettype wire

// File: dv/game_tb.sv
`timescale 1ns/1ps
`default_nettype none

module game_tb;

	logic        clk;
	logic        rst_n;
	logic        start_classic;
	logic        start_infinity;
	logic        hit;
	logic [15:0] sw;
	logic [15:0] led;
	logic [3:0]  an;
	logic [6:0]  seg;
	logic        active;
	int          checks;
	int          errors;
	bit          timed_out;

	game_top dut_i
	(
		.clk            (clk),
		.rst_n          (rst_n),
		.start_classic  (start_classic),
		.start_infinity (start_infinity),
		.hit            (hit),
		.sw             (sw),
		.led            (led),
		.an             (an),
		.seg            (seg),
		.active         (active)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Bar lit from LED 15 downward.
	function automatic logic [15:0] bar_of_level(input int lvl);
		logic [15:0] bar;
		bar = '0;
		for (int i = 0; i < 16; i++)
			bar[15 - i] = (i < lvl);
		return bar;
	endfunction

	// Decimal level field, X gives -1.
	function automatic int parse_level(input logic [63:0] tok);
		int value;
		value = 0;
		if (tok[7:0] == "X")
			return -1;
		for (int i = 7; i >= 0; i--)
			if (tok[i*8 +: 8] >= "0" && tok[i*8 +: 8] <= "9")
				value = value * 10 + (tok[i*8 +: 8] - "0");
		return value;
	endfunction

	task automatic compare(input logic [15:0] got, input logic [15:0] want, input string what);
		checks++;
		if (got !== want)
		begin
			errors++;
			$display("CHECK FAILED at %0t ns: %s, got %h, expected %h", $time, what, got, want);
		end
	endtask

	// Steps on falling edges until the anode match equals match.
	task automatic wait_digit_select(input logic [3:0] value, input bit match);
		int n;
		n = 0;
		while (((an == value) != match) && n < 8 * game_pkg::scan_cycles)
		begin
			@(negedge clk);
			n++;
		end
		if ((an == value) != match)
		begin
			timed_out = 1'b1;
			$display("Timeout while waiting for the digit select to reach %b.", value);
		end
	endtask

	task automatic check_digits(input logic [3:0] mode_d, input int score, input bit blanked);
		logic [3:0] digit_val [4];
		logic [6:0] want;
		digit_val[0] = 4'(score % 10);
		digit_val[1] = 4'(score / 10);
		digit_val[2] = 4'd0;
		digit_val[3] = mode_d;
		for (int d = 0; d < 4; d++)
		begin
			wait_digit_select(~(4'b0001 << d), 1'b1);
			if (timed_out)
				return;
			want = blanked ? game_pkg::seg_blank : game_pkg::seg_table[digit_val[d]];
			compare({9'd0, seg}, {9'd0, want}, $sformatf("segments of digit %0d", d));
		end
	endtask

	task automatic run_step(input logic [7:0] op, input int arg);
		case (op)
			"C", "I":
			begin
				@(posedge clk);
				#1 start_classic = (op == "C");
				start_infinity = (op == "I");
				@(posedge clk);
				#1 start_classic = 1'b0;
				start_infinity = 1'b0;
			end
			"H":
			begin
				repeat (arg)
				begin
					@(posedge clk);
					#1 hit = 1'b1;
					@(posedge clk);
					#1 hit = 1'b0;
				end
			end
			"W":
			begin
				repeat (arg) @(posedge clk);
				#1;
			end
			"B":
			begin
				@(posedge clk);
				#1 sw[0] = arg[0];
			end
			default:
			begin
				errors++;
				$display("Unknown operation %c in the pattern file.", op);
			end
		endcase
	endtask

	initial
	begin
		int fd;
		int step_no;
		int arg;
		int score;
		int act;
		int lvl;
		int err_before;
		int assert_fails;
		bit blanked;
		bit was_active;
		logic [3:0] mode_d;
		logic [8*96-1:0] line;
		logic [63:0] op;
		logic [63:0] lvl_tok;
		rst_n = 1'b0;
		start_classic = 1'b0;
		start_infinity = 1'b0;
		hit = 1'b0;
		sw = 16'h0000;
		{checks, errors, step_no, timed_out, blanked, was_active} = '0;
		mode_d = game_pkg::mode_code_none;
		void'($urandom(32'h6f64b271));
		repeat (2) @(posedge clk);
		#1 rst_n = 1'b1;
		fd = $fopen("dv/game_patterns.txt", "r");
		if (fd == 0)
			$display("Could not open the pattern file dv/game_patterns.txt.");
		while (fd != 0 && !timed_out && $fgets(line, fd) > 0)
		begin
			if ($sscanf(line, "%s %d %s %d %d", op, arg, lvl_tok, score, act) == 5)
			begin
				step_no++;
				err_before = errors;
				wait_digit_select(4'b1110, 1'b0); // Line up with the start of digit 0.
				wait_digit_select(4'b1110, 1'b1);
				if ((op[7:0] == "C" || op[7:0] == "I") && !was_active)
					mode_d = (op[7:0] == "C") ? game_pkg::mode_code_classic :
						game_pkg::mode_code_infinity;
				if (op[7:0] == "B")
					blanked = arg[0];
				run_step(op[7:0], arg);
				repeat (2) @(posedge clk);
				@(negedge clk);
				lvl = parse_level(lvl_tok);
				if (lvl < 0)
					compare(led, bar_of_level($countones(led)), "LED bar shape");
				else
					compare(led, bar_of_level(lvl), "LED bar level");
				compare({15'd0, active}, 16'(act), "game active");
				check_digits(mode_d, score, blanked);
				was_active = act[0];
				$display("step %0d %c %0d: %s", step_no, op[7:0], arg,
					(errors == err_before) ? "ok" : "mismatch");
				repeat ($urandom % 4) @(negedge clk); // Idle gap.
			end
		end
		if (fd != 0)
			$fclose(fd);
		assert_fails = dut_i.game_seg_and_led_i.game_properties_i.fail_cnt;
		$display("%0d steps, %0d checks, %0d errors, %0d assertion failures, timeout %0d",
			step_no, checks, errors, assert_fails, timed_out);
		if (errors == 0 && assert_fails == 0 && !timed_out && step_no > 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: dv/game_patterns.txt
# Columns: op, argument, level on led or X, score, active.
# C/I start a game, H gives n hits, W waits n cycles, B sets sw[0].
W 1   0  0  0
C 0   16 0  1
H 3   12 3  1
W 8   8  3  1
W 130 0  3  0
I 0   16 0  1
W 20  10 0  1
H 1   16 1  1
C 0   12 1  1
W 140 0  1  0
I 0   16 0  1
B 1   12 0  1
B 0   10 0  1
H 120 16 99 1
W 5   X  99 1

// File: compile.f
source/game_pkg.sv
source/seg7_scan.sv
source/game_seg_and_led.sv
source/game_fsm.sv
source/game_timer.sv
source/score_counter.sv
source/game_top.sv
dv/game_properties.sv
dv/game_tb.sv

// File: Bender.yml
package:
  name: reaction_game

sources:
  - files:
      - source/game_pkg.sv
      - source/seg7_scan.sv
      - source/game_seg_and_led.sv
      - source/game_fsm.sv
      - source/game_timer.sv
      - source/score_counter.sv
      - source/game_top.sv
  - target: test
    files:
      - dv/game_properties.sv
      - dv/game_tb.sv
